// ==== Makefile ====
# Verilator build for the mips_issue_ex slice

VERILATOR ?= verilator
FILELIST  ?= mips_issue_ex.f
TB_TOP    ?= tb_mips_issue_ex
RTL_TOP   ?= mips_issue_ex
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= ERRORS FOUND
VFLAGS    ?=

BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BIN)
	$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/ex_pipe_reg.sv ====
// Issue-Execute Pipeline Register

`timescale 1ns/1ps

module ex_pipe_reg
    (
        input  logic                clk,
        input  logic                reset,
        input  logic                clr_i,
        input  logic                reg_wr_i,
        input  logic                mem_wr_i,
        input  mips_pkg::alu_op_t   alu_op_i,
        input  logic                alu_src_i,
        input  logic                reg_dst_i,
        input  mips_pkg::reg_addr_t rs_i,
        input  mips_pkg::reg_addr_t rt_i,
        input  mips_pkg::reg_addr_t rd_i,
        input  mips_pkg::word_t     r_data_p1_i,
        input  mips_pkg::word_t     r_data_p2_i,
        input  mips_pkg::word_t     sign_imm_i,
        output logic                reg_wr_o,
        output logic                mem_wr_o,
        output mips_pkg::alu_op_t   alu_op_o,
        output logic                alu_src_o,
        output logic                reg_dst_o,
        output mips_pkg::reg_addr_t rs_o,
        output mips_pkg::reg_addr_t rt_o,
        output mips_pkg::reg_addr_t rd_o,
        output mips_pkg::word_t     r_data_p1_o,
        output mips_pkg::word_t     r_data_p2_o,
        output mips_pkg::word_t     sign_imm_o
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // clr_i turns whatever is being captured into a bubble.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            reg_wr_o    <= 1'b0;
            mem_wr_o    <= 1'b0;
            alu_op_o    <= '0;
            alu_src_o   <= 1'b0;
            reg_dst_o   <= 1'b0;
            rs_o        <= '0;
            rt_o        <= '0;
            rd_o        <= '0;
            r_data_p1_o <= '0;
            r_data_p2_o <= '0;
            sign_imm_o  <= '0;
        end
        else if (clr_i)
        begin
            reg_wr_o    <= 1'b0;
            mem_wr_o    <= 1'b0;
            alu_op_o    <= '0;
            alu_src_o   <= 1'b0;
            reg_dst_o   <= 1'b0;
            rs_o        <= '0;
            rt_o        <= '0;
            rd_o        <= '0;
            r_data_p1_o <= '0;
            r_data_p2_o <= '0;
            sign_imm_o  <= '0;
        end
        else
        begin
            reg_wr_o    <= reg_wr_i;
            mem_wr_o    <= mem_wr_i;
            alu_op_o    <= alu_op_i;
            alu_src_o   <= alu_src_i;
            reg_dst_o   <= reg_dst_i;
            rs_o        <= rs_i;
            rt_o        <= rt_i;
            rd_o        <= rd_i;
            r_data_p1_o <= r_data_p1_i;
            r_data_p2_o <= r_data_p2_i;
            sign_imm_o  <= sign_imm_i;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
// Execute Stage with Forwarding

`timescale 1ns/1ps

module execute_stage
    (
        input  logic                clk,
        input  logic                reset,
        input  logic                reg_wr_i,
        input  logic                mem_wr_i,
        input  mips_pkg::alu_op_t   alu_op_i,
        input  logic                alu_src_i,
        input  logic                reg_dst_i,
        input  mips_pkg::reg_addr_t rs_i,
        input  mips_pkg::reg_addr_t rt_i,
        input  mips_pkg::reg_addr_t rd_i,
        input  mips_pkg::word_t     r_data_p1_i,
        input  mips_pkg::word_t     r_data_p2_i,
        input  mips_pkg::word_t     sign_imm_i,
        output logic                wb_en_o,
        output mips_pkg::reg_addr_t wb_addr_o,
        output mips_pkg::word_t     wb_data_o,
        output logic                mem_wr_o,
        output mips_pkg::word_t     mem_addr_o,
        output mips_pkg::word_t     mem_wdata_o
    );

    logic                fwd_rs;
    logic                fwd_rt;
    mips_pkg::word_t     op_a;
    mips_pkg::word_t     op_rt;  // forwarded rt, also the store data.
    mips_pkg::word_t     op_b;
    mips_pkg::word_t     alu_result;
    mips_pkg::reg_addr_t dest;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // forwarding from write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign fwd_rs = wb_en_o && (wb_addr_o != '0) && (wb_addr_o == rs_i);
    assign fwd_rt = wb_en_o && (wb_addr_o != '0) && (wb_addr_o == rt_i);

    assign op_a  = fwd_rs ? wb_data_o : r_data_p1_i;
    assign op_rt = fwd_rt ? wb_data_o : r_data_p2_i;
    assign op_b  = alu_src_i ? sign_imm_i : op_rt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (alu_op_i)
            mips_pkg::FN_ADD: alu_result = op_a + op_b;
            mips_pkg::FN_SUB: alu_result = op_a - op_b;
            mips_pkg::FN_AND: alu_result = op_a & op_b;
            mips_pkg::FN_OR:  alu_result = op_a | op_b;
            mips_pkg::FN_XOR: alu_result = op_a ^ op_b;
            mips_pkg::FN_NOR: alu_result = ~(op_a | op_b);
            mips_pkg::FN_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:          alu_result = '0;
        endcase
    end

    assign dest = reg_dst_i ? rd_i : rt_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wb_en_o  <= 1'b0;
            mem_wr_o <= 1'b0;
        end
        else
        begin
            wb_en_o  <= reg_wr_i && (dest != '0);  // r0 writes vanish here.
            mem_wr_o <= mem_wr_i;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_addr_o   <= dest;
        wb_data_o   <= alu_result;
        mem_addr_o  <= alu_result;  // sw runs as add.
        mem_wdata_o <= op_rt;
    end

endmodule

// ==== hdl/issue_decode.sv ====
// Instruction Decode and Operand Read

`timescale 1ns/1ps

module issue_decode
    (
        input  logic                clk,
        input  logic                reset,
        input  logic                instr_valid_i,
        input  mips_pkg::word_t     instr_i,
        input  logic                wb_en_i,
        input  mips_pkg::reg_addr_t wb_addr_i,
        input  mips_pkg::word_t     wb_data_i,
        output logic                reg_wr_o,
        output logic                mem_wr_o,
        output mips_pkg::alu_op_t   alu_op_o,
        output logic                alu_src_o,
        output logic                reg_dst_o,
        output mips_pkg::reg_addr_t rs_o,
        output mips_pkg::reg_addr_t rt_o,
        output mips_pkg::reg_addr_t rd_o,
        output mips_pkg::word_t     r_data_p1_o,
        output mips_pkg::word_t     r_data_p2_o,
        output mips_pkg::word_t     sign_imm_o
    );

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic        known_alu;  // recognised alu instruction.
    logic        is_store;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field split
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode     = instr_i[31:26];
    assign rs_o       = instr_i[25:21];
    assign rt_o       = instr_i[20:16];
    assign rd_o       = instr_i[15:11];
    assign funct      = instr_i[5:0];
    assign imm        = instr_i[15:0];
    assign sign_imm_o = {{16{imm[15]}}, imm};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        known_alu = 1'b0;
        is_store  = 1'b0;
        alu_op_o  = mips_pkg::FN_ADD;
        alu_src_o = 1'b1;  // immediate unless r-type.
        reg_dst_o = 1'b0;
        case (opcode)
            mips_pkg::OPC_RTYPE:
            begin
                alu_op_o  = funct;
                alu_src_o = 1'b0;
                reg_dst_o = 1'b1;
                case (funct)
                    mips_pkg::FN_ADD, mips_pkg::FN_SUB, mips_pkg::FN_AND,
                    mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
                    mips_pkg::FN_SLT: known_alu = 1'b1;
                    default:          known_alu = 1'b0;
                endcase
            end
            mips_pkg::OPC_ADDI: known_alu = 1'b1;
            mips_pkg::OPC_ANDI:
            begin
                alu_op_o  = mips_pkg::FN_AND;
                known_alu = 1'b1;
            end
            mips_pkg::OPC_ORI:
            begin
                alu_op_o  = mips_pkg::FN_OR;
                known_alu = 1'b1;
            end
            mips_pkg::OPC_SLTI:
            begin
                alu_op_o  = mips_pkg::FN_SLT;
                known_alu = 1'b1;
            end
            mips_pkg::OPC_SW: is_store = 1'b1;  // address is rs + imm.
            default: known_alu = 1'b0;
        endcase
    end

    // anything unrecognised goes down the pipe as a bubble.
    assign reg_wr_o = instr_valid_i && known_alu;
    assign mem_wr_o = instr_valid_i && is_store;

    reg_file u_reg_file
    (
        .clk       (clk),
        .reset     (reset),
        .rs_addr_i (rs_o),
        .rt_addr_i (rt_o),
        .wr_en_i   (wb_en_i),
        .wr_addr_i (wb_addr_i),
        .wr_data_i (wb_data_i),
        .rs_data_o (r_data_p1_o),
        .rt_data_o (r_data_p2_o)
    );

endmodule

// ==== hdl/mips_issue_ex.sv ====
// MIPS Issue-Execute Slice Top

`timescale 1ns/1ps

module mips_issue_ex
    (
        input  logic                clk,
        input  logic                reset,
        input  logic                instr_valid_i,
        input  mips_pkg::word_t     instr_i,
        input  logic                flush_i,
        output logic                result_valid_o,
        output mips_pkg::reg_addr_t result_dest_o,
        output mips_pkg::word_t     result_o,
        output logic                mem_wr_o,
        output mips_pkg::word_t     mem_addr_o,
        output mips_pkg::word_t     mem_wdata_o
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                id_reg_wr;
    logic                id_mem_wr;
    mips_pkg::alu_op_t   id_alu_op;
    logic                id_alu_src;
    logic                id_reg_dst;
    mips_pkg::reg_addr_t id_rs;
    mips_pkg::reg_addr_t id_rt;
    mips_pkg::reg_addr_t id_rd;
    mips_pkg::word_t     id_r_data_p1;
    mips_pkg::word_t     id_r_data_p2;
    mips_pkg::word_t     id_sign_imm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline register outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic                ex_reg_wr;
    logic                ex_mem_wr;
    mips_pkg::alu_op_t   ex_alu_op;
    logic                ex_alu_src;
    logic                ex_reg_dst;
    mips_pkg::reg_addr_t ex_rs;
    mips_pkg::reg_addr_t ex_rt;
    mips_pkg::reg_addr_t ex_rd;
    mips_pkg::word_t     ex_r_data_p1;
    mips_pkg::word_t     ex_r_data_p2;
    mips_pkg::word_t     ex_sign_imm;

    issue_decode u_issue_decode
    (
        .clk           (clk),
        .reset         (reset),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_en_i       (result_valid_o),  // write-back loops to the regfile.
        .wb_addr_i     (result_dest_o),
        .wb_data_i     (result_o),
        .reg_wr_o      (id_reg_wr),
        .mem_wr_o      (id_mem_wr),
        .alu_op_o      (id_alu_op),
        .alu_src_o     (id_alu_src),
        .reg_dst_o     (id_reg_dst),
        .rs_o          (id_rs),
        .rt_o          (id_rt),
        .rd_o          (id_rd),
        .r_data_p1_o   (id_r_data_p1),
        .r_data_p2_o   (id_r_data_p2),
        .sign_imm_o    (id_sign_imm)
    );

    ex_pipe_reg u_ex_pipe_reg
    (
        .clk         (clk),
        .reset       (reset),
        .clr_i       (flush_i),
        .reg_wr_i    (id_reg_wr),
        .mem_wr_i    (id_mem_wr),
        .alu_op_i    (id_alu_op),
        .alu_src_i   (id_alu_src),
        .reg_dst_i   (id_reg_dst),
        .rs_i        (id_rs),
        .rt_i        (id_rt),
        .rd_i        (id_rd),
        .r_data_p1_i (id_r_data_p1),
        .r_data_p2_i (id_r_data_p2),
        .sign_imm_i  (id_sign_imm),
        .reg_wr_o    (ex_reg_wr),
        .mem_wr_o    (ex_mem_wr),
        .alu_op_o    (ex_alu_op),
        .alu_src_o   (ex_alu_src),
        .reg_dst_o   (ex_reg_dst),
        .rs_o        (ex_rs),
        .rt_o        (ex_rt),
        .rd_o        (ex_rd),
        .r_data_p1_o (ex_r_data_p1),
        .r_data_p2_o (ex_r_data_p2),
        .sign_imm_o  (ex_sign_imm)
    );

    execute_stage u_execute_stage
    (
        .clk         (clk),
        .reset       (reset),
        .reg_wr_i    (ex_reg_wr),
        .mem_wr_i    (ex_mem_wr),
        .alu_op_i    (ex_alu_op),
        .alu_src_i   (ex_alu_src),
        .reg_dst_i   (ex_reg_dst),
        .rs_i        (ex_rs),
        .rt_i        (ex_rt),
        .rd_i        (ex_rd),
        .r_data_p1_i (ex_r_data_p1),
        .r_data_p2_i (ex_r_data_p2),
        .sign_imm_i  (ex_sign_imm),
        .wb_en_o     (result_valid_o),
        .wb_addr_o   (result_dest_o),
        .wb_data_o   (result_o),
        .mem_wr_o    (mem_wr_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

endmodule

// ==== hdl/mips_pkg.sv ====
// MIPS issue/execute shared definitions

package mips_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] word_t;      // register and alu data.
    typedef logic [4:0]  reg_addr_t;  // rs, rt, rd index.
    typedef logic [5:0]  alu_op_t;    // same code space as funct.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // primary opcodes, instr[31:26]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_SLTI  = 6'h0a;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_SW    = 6'h2b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // r-type funct, instr[5:0]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // i-type ops are decoded onto these same values.
    localparam alu_op_t FN_ADD = 6'h20;
    localparam alu_op_t FN_SUB = 6'h22;
    localparam alu_op_t FN_AND = 6'h24;
    localparam alu_op_t FN_OR  = 6'h25;
    localparam alu_op_t FN_XOR = 6'h26;
    localparam alu_op_t FN_NOR = 6'h27;
    localparam alu_op_t FN_SLT = 6'h2a;

endpackage

// ==== hdl/reg_file.sv ====
// Integer Register File

`timescale 1ns/1ps

module reg_file
    (
        input  logic               clk,
        input  logic               reset,
        input  mips_pkg::reg_addr_t rs_addr_i,
        input  mips_pkg::reg_addr_t rt_addr_i,
        input  logic               wr_en_i,
        input  mips_pkg::reg_addr_t wr_addr_i,
        input  mips_pkg::word_t     wr_data_i,
        output mips_pkg::word_t     rs_data_o,
        output mips_pkg::word_t     rt_data_o
    );

    mips_pkg::word_t regs [1:31];  // r0 has no storage.
    logic            wr_act;

    assign wr_act = wr_en_i && (wr_addr_i != '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_act)
        begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through, so a same-cycle reader sees the new value.
    always_comb
    begin
        if (rs_addr_i == '0)
            rs_data_o = '0;
        else if (wr_act && (wr_addr_i == rs_addr_i))
            rs_data_o = wr_data_i;
        else
            rs_data_o = regs[rs_addr_i];
    end

    always_comb
    begin
        if (rt_addr_i == '0)
            rt_data_o = '0;
        else if (wr_act && (wr_addr_i == rt_addr_i))
            rt_data_o = wr_data_i;
        else
            rt_data_o = regs[rt_addr_i];
    end

endmodule

// ==== mips_issue_ex.f ====
hdl/mips_pkg.sv
hdl/reg_file.sv
hdl/issue_decode.sv
hdl/ex_pipe_reg.sv
hdl/execute_stage.sv
hdl/mips_issue_ex.sv
sim/tb_mips_issue_ex.sv

// ==== sim/tb_mips_issue_ex.sv ====
// MIPS Issue-Execute Testbench

`timescale 1ns/1ps

module tb_mips_issue_ex;

    logic                clk;
    logic                reset;
    logic                instr_valid_i;
    mips_pkg::word_t     instr_i;
    logic                flush_i;
    logic                result_valid_o;
    mips_pkg::reg_addr_t result_dest_o;
    mips_pkg::word_t     result_o;
    logic                mem_wr_o;
    mips_pkg::word_t     mem_addr_o;
    mips_pkg::word_t     mem_wdata_o;

    logic [31:0] model_regs [0:31];  // in-order architectural state.
    logic [31:0] rng_state = 32'd18;
    int          neg_count = 0;
    int          head = 0;  // next expectation the monitor consumes.
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    // one expected output per instruction that should show up.
    bit          exp_store [$];
    logic [4:0]  exp_dest [$];
    logic [31:0] exp_val [$];  // result or store address.
    logic [31:0] exp_wdata [$];
    int          exp_due [$];

    mips_issue_ex dut_i
    (
        .clk            (clk),
        .reset          (reset),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .flush_i        (flush_i),
        .result_valid_o (result_valid_o),
        .result_dest_o  (result_dest_o),
        .result_o       (result_o),
        .mem_wr_o       (mem_wr_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] r_op(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
        return {mips_pkg::OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_op(input logic [5:0] opc, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [5:0] fn_by_index(input int idx);
        case (idx)
            0:       return mips_pkg::FN_ADD;
            1:       return mips_pkg::FN_SUB;
            2:       return mips_pkg::FN_AND;
            3:       return mips_pkg::FN_OR;
            4:       return mips_pkg::FN_XOR;
            5:       return mips_pkg::FN_NOR;
            default: return mips_pkg::FN_SLT;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [5:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            mips_pkg::FN_ADD: return a + b;
            mips_pkg::FN_SUB: return a - b;
            mips_pkg::FN_AND: return a & b;
            mips_pkg::FN_OR:  return a | b;
            mips_pkg::FN_XOR: return a ^ b;
            mips_pkg::FN_NOR: return ~(a | b);
            mips_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return 32'd0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v)
        begin
            $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    // executes one instruction on the model and queues what the DUT owes.
    task automatic model_step(input logic [31:0] instr, input logic flush);
        logic [5:0]  opc;
        logic [5:0]  op;
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] bt;
        logic [31:0] imm;
        logic [31:0] val;
        logic        known;
        opc   = instr[31:26];
        a     = model_regs[instr[25:21]];
        bt    = model_regs[instr[20:16]];
        imm   = {{16{instr[15]}}, instr[15:0]};
        known = 1'b1;
        op    = mips_pkg::FN_ADD;
        dest  = instr[20:16];
        case (opc)
            mips_pkg::OPC_RTYPE:
            begin
                op   = instr[5:0];
                dest = instr[15:11];
                case (op)
                    mips_pkg::FN_ADD, mips_pkg::FN_SUB, mips_pkg::FN_AND, mips_pkg::FN_OR,
                    mips_pkg::FN_XOR, mips_pkg::FN_NOR, mips_pkg::FN_SLT: known = 1'b1;
                    default: known = 1'b0;
                endcase
            end
            mips_pkg::OPC_ADDI: op = mips_pkg::FN_ADD;
            mips_pkg::OPC_ANDI: op = mips_pkg::FN_AND;
            mips_pkg::OPC_ORI:  op = mips_pkg::FN_OR;
            mips_pkg::OPC_SLTI: op = mips_pkg::FN_SLT;
            mips_pkg::OPC_SW:   op = mips_pkg::FN_ADD;
            default:            known = 1'b0;
        endcase
        if (flush || !known)
            return;
        val = alu_ref(op, a, (opc == mips_pkg::OPC_RTYPE) ? bt : imm);
        if (opc == mips_pkg::OPC_SW || dest != 5'd0)
        begin
            exp_store.push_back(opc == mips_pkg::OPC_SW);
            exp_dest.push_back(dest);
            exp_val.push_back(val);
            exp_wdata.push_back(bt);
            exp_due.push_back(neg_count + 3);  // falling edge after edge N+2.
        end
        if (opc != mips_pkg::OPC_SW && dest != 5'd0)
            model_regs[dest] = val;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drive and wait
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic issue(input logic [31:0] instr, input logic flush);
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
        flush_i       <= flush;
        model_step(instr, flush);
    endtask

    task automatic idle();
        @(posedge clk);
        instr_valid_i <= 1'b0;
        flush_i       <= 1'b0;
    endtask

    task automatic run_one(input logic [31:0] instr);
        issue(instr, 1'b0);
        idle();
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (head != exp_due.size() && waited < 20)
        begin
            @(posedge clk);
            waited++;
        end
        if (head != exp_due.size())
        begin
            $display("timeout with %0d results still outstanding", exp_due.size() - head);
            timeouts++;
        end
    endtask

    // compares every DUT output pulse against the queue in order.
    always @(negedge clk)
    begin
        neg_count = neg_count + 1;
        if (!reset)
        begin
            if (result_valid_o || mem_wr_o)
            begin
                if (head >= exp_due.size())
                begin
                    $display("output pulse at cycle %0d with nothing outstanding", neg_count);
                    errors++;
                end
                else
                begin
                    check("result cycle", exp_due[head], neg_count);
                    check("result_valid_o", {31'b0, ~exp_store[head]}, {31'b0, result_valid_o});
                    check("mem_wr_o", {31'b0, exp_store[head]}, {31'b0, mem_wr_o});
                    if (exp_store[head])
                    begin
                        check("mem_addr_o", exp_val[head], mem_addr_o);
                        check("mem_wdata_o", exp_wdata[head], mem_wdata_o);
                    end
                    else
                    begin
                        check("result_dest_o", {27'b0, exp_dest[head]}, {27'b0, result_dest_o});
                        check("result_o", exp_val[head], result_o);
                    end
                    head++;
                end
            end
            else if (head < exp_due.size() && exp_due[head] <= neg_count)
            begin
                $display("output due at cycle %0d never appeared", exp_due[head]);
                errors++;
                head++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset();
        repeat (5) idle();  // monitor flags any stray pulse.
        run_one(r_op(mips_pkg::FN_ADD, 5'd1, 5'd31, 5'd30));  // untouched since reset.
        drain();
    endtask

    task automatic test_alu_ops();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        rd = 5'd1;
        for (int i = 0; i < 8; i++)
        begin
            r = rand32();
            if (i == 0)
                r[15] = 1'b1;  // r1 negative.
            if (i == 1)
                r[15] = 1'b0;
            run_one(i_op(mips_pkg::OPC_ADDI, rd, 5'd0, r[15:0]));
            rd = rd + 5'd1;
        end
        rd = 5'd9;
        for (int i = 0; i < 7; i++)
        begin
            r  = rand32();
            rs = 5'd1 + {2'b0, r[2:0]};
            rt = 5'd1 + {2'b0, r[5:3]};
            run_one(r_op(fn_by_index(i), rd, rs, rt));
            rd = rd + 5'd1;
        end
        run_one(r_op(mips_pkg::FN_SLT, 5'd16, 5'd1, 5'd2));
        run_one(r_op(mips_pkg::FN_SLT, 5'd17, 5'd2, 5'd1));
        r = rand32();
        run_one(i_op(mips_pkg::OPC_ADDI, 5'd18, 5'd2, {1'b1, r[14:0]}));
        run_one(i_op(mips_pkg::OPC_ANDI, 5'd19, 5'd3, r[31:16]));
        run_one(i_op(mips_pkg::OPC_ORI, 5'd20, 5'd4, r[15:0]));
        run_one(i_op(mips_pkg::OPC_SLTI, 5'd21, 5'd1, 16'hfff0));
        run_one(i_op(mips_pkg::OPC_SLTI, 5'd22, 5'd2, 16'hfff0));
        drain();
    endtask

    task automatic test_back_to_back();
        logic [31:0] r;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        logic [4:0]  rd;
        prev1 = 5'd1;
        prev2 = 5'd2;
        rd    = 5'd23;
        for (int i = 0; i < 12; i++)
        begin
            r = rand32();
            issue(r_op(fn_by_index(r % 7), rd, prev1, prev2), 1'b0);
            prev2 = prev1;
            prev1 = rd;
            rd    = (rd == 5'd30) ? 5'd23 : rd + 5'd1;
        end
        idle();
        drain();
    endtask

    task automatic test_zero_and_bubbles();
        run_one(i_op(mips_pkg::OPC_ADDI, 5'd0, 5'd1, 16'h0005));
        run_one(r_op(mips_pkg::FN_ADD, 5'd6, 5'd0, 5'd7));
        run_one(i_op(mips_pkg::OPC_ORI, 5'd7, 5'd0, 16'h0007));
        run_one({6'h3f, 26'h1234567});  // unknown opcode.
        run_one(r_op(6'h3f, 5'd8, 5'd1, 5'd2));  // unknown funct.
        drain();
    endtask

    task automatic test_flush();
        issue(i_op(mips_pkg::OPC_ADDI, 5'd4, 5'd0, 16'h0111), 1'b0);
        issue(i_op(mips_pkg::OPC_ADDI, 5'd4, 5'd0, 16'h0222), 1'b1);
        issue(r_op(mips_pkg::FN_ADD, 5'd5, 5'd4, 5'd0), 1'b0);
        idle();
        drain();
    endtask

    task automatic test_store();
        run_one(i_op(mips_pkg::OPC_SW, 5'd5, 5'd1, 16'hfff8));
        issue(i_op(mips_pkg::OPC_ADDI, 5'd2, 5'd0, 16'h1234), 1'b0);
        issue(i_op(mips_pkg::OPC_SW, 5'd2, 5'd3, 16'h0010), 1'b0);  // data forwarded.
        idle();
        drain();
    endtask

    initial
    begin
        reset         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        flush_i       = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'd0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_alu_ops();
        test_back_to_back();
        test_zero_and_bubbles();
        test_flush();
        test_store();
        repeat (3) idle();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
